// ==== logic/conv_pkg.sv ====
package conv_pkg;

  ////////////////////////////////////////
  // Sample and coefficient formats
  ////////////////////////////////////////

  // Unsigned grey-scale sample
  typedef logic [7:0] pixel_t;

  // Signed kernel coefficient
  typedef logic signed [7:0] weight_t;

  ////////////////////////////////////////
  // Arithmetic widths
  ////////////////////////////////////////

  // Zero-extended pixel (9 bits signed) times weight
  typedef logic signed [16:0] product_t;

  // Nine products need four more bits of headroom
  typedef logic signed [20:0] result_t;

  // Window positions and the weight address that selects one
  localparam int KERNEL_TAPS = 9;

  typedef logic [3:0] tap_index_t;

endpackage

// ==== logic/flow_pkg.sv ====
package flow_pkg;

  ////////////////////////////////////////
  // Flow-control counters
  ////////////////////////////////////////

  // Holds up to 16 credits
  typedef logic [4:0] credit_cnt_t;

  // Stored entries plus outstanding reservations
  typedef logic [4:0] queue_cnt_t;

endpackage

// ==== logic/conv_window_if.sv ====
`timescale 1ns/100ps

interface conv_window_if;
  import conv_pkg::*;

  // High for one cycle per complete window
  logic   win_valid;

  // Tap 0 is top-left and tap 8 is the newest pixel
  pixel_t tap [KERNEL_TAPS];

  // Line buffer side
  modport src (output win_valid, output tap);

  // Convolution core side
  modport dst (input win_valid, input tap);

  // Result queue watches for windows to reserve a slot
  modport mon (input win_valid);

endinterface

// ==== logic/pixel_queue.sv ====
`timescale 1ns/100ps

module pixel_queue #(
  parameter int IN_DEPTH = 4
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             pixel_valid,
  input  conv_pkg::pixel_t pixel_data,
  input  logic             pq_pop,
  output logic             pq_valid,
  output conv_pkg::pixel_t pq_data,
  output logic             pix_credit
);
  import conv_pkg::*;
  import flow_pkg::*;

  localparam int               PTR_W = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
  localparam logic [PTR_W-1:0] LAST  = PTR_W'(IN_DEPTH - 1);

  pixel_t           mem [IN_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  queue_cnt_t       count;
  logic             pop;

  assign pq_valid = (count != '0);
  assign pq_data  = mem[rd_ptr];
  assign pop      = pq_pop && pq_valid;

  // Pixel storage
  always_ff @(posedge clk) begin
    if (pixel_valid) begin
      mem[wr_ptr] <= pixel_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      pix_credit <= 1'b0;
    end else begin
      // Source holds a credit for every push, so no full check
      if (pixel_valid) begin
        wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
      end
      case ({pixel_valid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // Freed slot goes back to the source
      pix_credit <= pop;
    end
  end

endmodule

// ==== logic/line_buffer.sv ====
`timescale 1ns/100ps

module line_buffer #(
  parameter int IMAGE_WIDTH  = 8,
  parameter int IMAGE_HEIGHT = 6
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             pq_valid,
  input  conv_pkg::pixel_t pq_data,
  input  logic             room,
  output logic             pq_pop,
  conv_window_if.src       win
);
  import conv_pkg::*;

  localparam int               COL_W    = (IMAGE_WIDTH > 1) ? $clog2(IMAGE_WIDTH) : 1;
  localparam int               ROW_W    = (IMAGE_HEIGHT > 1) ? $clog2(IMAGE_HEIGHT) : 1;
  localparam logic [COL_W-1:0] COL_LAST = COL_W'(IMAGE_WIDTH - 1);
  localparam logic [ROW_W-1:0] ROW_LAST = ROW_W'(IMAGE_HEIGHT - 1);

  pixel_t           line0 [IMAGE_WIDTH];
  pixel_t           line1 [IMAGE_WIDTH];
  pixel_t           above1;
  pixel_t           above2;
  logic [COL_W-1:0] col;
  logic [ROW_W-1:0] row;
  logic             completes;

  // Same column, one and two rows up
  assign above1 = line0[IMAGE_WIDTH-1];
  assign above2 = line1[IMAGE_WIDTH-1];

  // Only a pixel that finishes a window needs a result slot
  assign completes = (col >= COL_W'(2)) && (row >= ROW_W'(2));
  assign pq_pop    = pq_valid && (!completes || room);

  ////////////////////////////////////////
  // Row delay lines
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (pq_pop) begin
      line0[0] <= pq_data;
      line1[0] <= above1;
      for (int i = 1; i < IMAGE_WIDTH; i++) begin
        line0[i] <= line0[i-1];
        line1[i] <= line1[i-1];
      end
    end
  end

  ////////////////////////////////////////
  // 3x3 window
  ////////////////////////////////////////

  // Columns move left, new column enters on the right
  always_ff @(posedge clk) begin
    if (pq_pop) begin
      for (int r = 0; r < 3; r++) begin
        win.tap[3*r]   <= win.tap[3*r+1];
        win.tap[3*r+1] <= win.tap[3*r+2];
      end
      win.tap[2] <= above2;
      win.tap[5] <= above1;
      win.tap[8] <= pq_data;
    end
  end

  // Raster position of the next pixel
  always_ff @(posedge clk) begin
    if (reset) begin
      col           <= '0;
      row           <= '0;
      win.win_valid <= 1'b0;
    end else begin
      win.win_valid <= pq_pop && completes;
      if (pq_pop) begin
        if (col == COL_LAST) begin
          col <= '0;
          row <= (row == ROW_LAST) ? '0 : row + 1'b1;
        end else begin
          col <= col + 1'b1;
        end
      end
    end
  end

endmodule

// ==== logic/conv_3x3_core.sv ====
`timescale 1ns/100ps

module conv_3x3_core (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 weight_wr,
  input  conv_pkg::tap_index_t weight_addr,
  input  conv_pkg::weight_t    weight_data,
  conv_window_if.dst           win,
  output logic                 core_valid,
  output conv_pkg::result_t    core_data
);
  import conv_pkg::*;

  localparam int STAGES = 6;

  weight_t           weights [KERNEL_TAPS];
  pixel_t            s1_pix  [KERNEL_TAPS];
  product_t          s2_prod [KERNEL_TAPS];
  result_t           s3_sum  [5];
  result_t           s4_sum  [3];
  result_t           s5_sum  [2];
  logic [STAGES-1:0] stage_valid;

  ////////////////////////////////////////
  // Weight bank
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < KERNEL_TAPS; i++) begin
        weights[i] <= '0;
      end
    end else if (weight_wr && (int'(weight_addr) < KERNEL_TAPS)) begin
      weights[weight_addr] <= weight_data;
    end
  end

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    // Stage 1 captures the window
    for (int i = 0; i < KERNEL_TAPS; i++) begin
      s1_pix[i] <= win.tap[i];
    end

    // Stage 2, pixel is zero-extended before the signed multiply
    for (int i = 0; i < KERNEL_TAPS; i++) begin
      s2_prod[i] <= $signed({1'b0, s1_pix[i]}) * weights[i];
    end

    // Stage 3 pairs products, the last one rides along
    for (int i = 0; i < 4; i++) begin
      s3_sum[i] <= result_t'(s2_prod[2*i]) + result_t'(s2_prod[2*i+1]);
    end
    s3_sum[4] <= result_t'(s2_prod[8]);

    // Stage 4
    s4_sum[0] <= s3_sum[0] + s3_sum[1];
    s4_sum[1] <= s3_sum[2] + s3_sum[3];
    s4_sum[2] <= s3_sum[4];

    // Stage 5
    s5_sum[0] <= s4_sum[0] + s4_sum[1];
    s5_sum[1] <= s4_sum[2];

    // Stage 6
    core_data <= s5_sum[0] + s5_sum[1];
  end

  // Valid bit follows the data one stage at a time
  always_ff @(posedge clk) begin
    if (reset) begin
      stage_valid <= '0;
    end else begin
      stage_valid <= {stage_valid[STAGES-2:0], win.win_valid};
    end
  end

  assign core_valid = stage_valid[STAGES-1];

endmodule

// ==== logic/result_queue.sv ====
`timescale 1ns/100ps

module result_queue #(
  parameter int OUT_DEPTH   = 8,
  parameter int OUT_CREDITS = 4
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              core_valid,
  input  conv_pkg::result_t core_data,
  input  logic              result_credit,
  conv_window_if.mon        win,
  output logic              room,
  output logic              result_valid,
  output conv_pkg::result_t result_data
);
  import conv_pkg::*;
  import flow_pkg::*;

  localparam int               PTR_W = (OUT_DEPTH > 1) ? $clog2(OUT_DEPTH) : 1;
  localparam logic [PTR_W-1:0] LAST  = PTR_W'(OUT_DEPTH - 1);

  result_t          mem [OUT_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  queue_cnt_t       count;
  queue_cnt_t       reserved;
  credit_cnt_t      credits;
  logic             send;

  assign send = (credits != '0) && (count != '0);

  // A window seen this cycle already holds a slot
  assign room = (int'(count) + int'(reserved) + int'(win.win_valid)) < OUT_DEPTH;

  ////////////////////////////////////////
  // Storage and output
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (core_valid) begin
      mem[wr_ptr] <= core_data;
    end
    if (send) begin
      result_data <= mem[rd_ptr];
    end
  end

  ////////////////////////////////////////
  // Pointers and counters
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      count        <= '0;
      reserved     <= '0;
      credits      <= credit_cnt_t'(OUT_CREDITS);
      result_valid <= 1'b0;
    end else begin
      result_valid <= send;
      if (core_valid) begin
        wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (send) begin
        rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
      end
      case ({core_valid, send})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // Slot moves from reserved to stored when the core writes
      case ({win.win_valid, core_valid})
        2'b10:   reserved <= reserved + 1'b1;
        2'b01:   reserved <= reserved - 1'b1;
        default: reserved <= reserved;
      endcase
      // Spend and return may land in the same cycle
      case ({send, result_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

endmodule

// ==== logic/conv_engine_top.sv ====
`timescale 1ns/100ps

module conv_engine_top #(
  parameter int IMAGE_WIDTH  = 8,
  parameter int IMAGE_HEIGHT = 6,
  parameter int IN_DEPTH     = 4,
  parameter int OUT_DEPTH    = 8,
  parameter int OUT_CREDITS  = 4
) (
  input  logic                 clk,
  input  logic                 reset,
  // Pixel stream
  input  logic                 pixel_valid,
  input  conv_pkg::pixel_t     pixel_data,
  output logic                 pix_credit,
  // Weight write port
  input  logic                 weight_wr,
  input  conv_pkg::tap_index_t weight_addr,
  input  conv_pkg::weight_t    weight_data,
  // Result stream
  output logic                 result_valid,
  output conv_pkg::result_t    result_data,
  input  logic                 result_credit
);
  import conv_pkg::*;

  logic    pq_valid;
  pixel_t  pq_data;
  logic    pq_pop;
  logic    room;
  logic    core_valid;
  result_t core_data;

  conv_window_if win_if ();

  ////////////////////////////////////////
  // Input side
  ////////////////////////////////////////

  pixel_queue #(
    .IN_DEPTH (IN_DEPTH)
  ) pixel_queue_i (
    .clk         (clk),
    .reset       (reset),
    .pixel_valid (pixel_valid),
    .pixel_data  (pixel_data),
    .pq_pop      (pq_pop),
    .pq_valid    (pq_valid),
    .pq_data     (pq_data),
    .pix_credit  (pix_credit)
  );

  line_buffer #(
    .IMAGE_WIDTH  (IMAGE_WIDTH),
    .IMAGE_HEIGHT (IMAGE_HEIGHT)
  ) line_buffer_i (
    .clk      (clk),
    .reset    (reset),
    .pq_valid (pq_valid),
    .pq_data  (pq_data),
    .room     (room),
    .pq_pop   (pq_pop),
    .win      (win_if.src)
  );

  ////////////////////////////////////////
  // Compute and output side
  ////////////////////////////////////////

  conv_3x3_core conv_3x3_core_i (
    .clk         (clk),
    .reset       (reset),
    .weight_wr   (weight_wr),
    .weight_addr (weight_addr),
    .weight_data (weight_data),
    .win         (win_if.dst),
    .core_valid  (core_valid),
    .core_data   (core_data)
  );

  result_queue #(
    .OUT_DEPTH   (OUT_DEPTH),
    .OUT_CREDITS (OUT_CREDITS)
  ) result_queue_i (
    .clk           (clk),
    .reset         (reset),
    .core_valid    (core_valid),
    .core_data     (core_data),
    .result_credit (result_credit),
    .win           (win_if.mon),
    .room          (room),
    .result_valid  (result_valid),
    .result_data   (result_data)
  );

endmodule

// ==== verif/conv_engine_tb.sv ====
`timescale 1ns/100ps

module conv_engine_tb;
  import conv_pkg::*;

  localparam int          IMAGE_WIDTH    = 8;
  localparam int          IMAGE_HEIGHT   = 6;
  localparam int          IN_DEPTH       = 4;
  localparam int          OUT_DEPTH      = 8;
  localparam int          OUT_CREDITS    = 4;
  localparam int          NUM_FRAMES     = 4;
  localparam int          FRAME_RESULTS  = (IMAGE_WIDTH - 2) * (IMAGE_HEIGHT - 2);
  localparam int          TOTAL_RESULTS  = NUM_FRAMES * FRAME_RESULTS;
  localparam int          TIMEOUT_CYCLES = 200 * TOTAL_RESULTS + 500;
  localparam int unsigned SEED           = 32'h6be270eb;

  logic       clk;
  logic       reset;
  logic       pixel_valid;
  pixel_t     pixel_data;
  logic       pix_credit;
  logic       weight_wr;
  tap_index_t weight_addr;
  weight_t    weight_data;
  logic       result_valid;
  result_t    result_data;
  logic       result_credit;

  int   kernel [KERNEL_TAPS];
  int   frame_pix [IMAGE_HEIGHT][IMAGE_WIDTH];
  int   expected_q [$];
  int   credit_due [$];
  int   cycle = 0;
  int   driver_sent = 0;
  int   pixels_sent = 0;
  int   pix_credits_seen = 0;
  int   results_seen = 0;
  int   result_credits_seen = 0;
  int   value_errors = 0;
  int   flow_errors = 0;
  logic after_reset = 1'b1;

  conv_engine_top #(
    .IMAGE_WIDTH  (IMAGE_WIDTH),
    .IMAGE_HEIGHT (IMAGE_HEIGHT),
    .IN_DEPTH     (IN_DEPTH),
    .OUT_DEPTH    (OUT_DEPTH),
    .OUT_CREDITS  (OUT_CREDITS)
  ) conv_engine_top_i (
    .clk           (clk),
    .reset         (reset),
    .pixel_valid   (pixel_valid),
    .pixel_data    (pixel_data),
    .pix_credit    (pix_credit),
    .weight_wr     (weight_wr),
    .weight_addr   (weight_addr),
    .weight_data   (weight_data),
    .result_valid  (result_valid),
    .result_data   (result_data),
    .result_credit (result_credit)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////
  // Error reporting
  ////////////////////////////////////////

  task automatic value_mismatch(input int got, input int want);
    value_errors++;
    $display("CHECK FAILED at %0t: result %0d, expected %0d", $time, got, want);
  endtask

  task automatic flow_violation(input string what);
    flow_errors++;
    $display("CHECK FAILED at %0t: %s", $time, what);
  endtask

  task automatic print_summary();
    $display("Summary: %0d value errors, %0d flow errors, %0d/%0d results, %0d/%0d credits",
             value_errors, flow_errors, results_seen, TOTAL_RESULTS,
             pix_credits_seen, pixels_sent);
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic fill_random_frame();
    for (int r = 0; r < IMAGE_HEIGHT; r++) begin
      for (int c = 0; c < IMAGE_WIDTH; c++) begin
        frame_pix[r][c] = int'($urandom_range(0, 255));
      end
    end
  endtask

  task automatic fill_flat_frame(input int value);
    for (int r = 0; r < IMAGE_HEIGHT; r++) begin
      for (int c = 0; c < IMAGE_WIDTH; c++) begin
        frame_pix[r][c] = value;
      end
    end
  endtask

  task automatic fill_random_kernel();
    for (int k = 0; k < KERNEL_TAPS; k++) begin
      kernel[k] = int'($urandom_range(0, 255)) - 128;
    end
  endtask

  task automatic fill_flat_kernel(input int value);
    for (int k = 0; k < KERNEL_TAPS; k++) begin
      kernel[k] = value;
    end
  endtask

  task automatic load_kernel();
    for (int k = 0; k < KERNEL_TAPS; k++) begin
      @(posedge clk);
      weight_wr   <= 1'b1;
      weight_addr <= tap_index_t'(k);
      weight_data <= weight_t'(kernel[k]);
    end
    @(posedge clk);
    weight_wr <= 1'b0;
  endtask

  // Reference sum for every full window in raster order
  task automatic predict_frame();
    int sum;
    for (int r = 2; r < IMAGE_HEIGHT; r++) begin
      for (int c = 2; c < IMAGE_WIDTH; c++) begin
        sum = 0;
        for (int k = 0; k < KERNEL_TAPS; k++) begin
          sum += kernel[k] * frame_pix[r - 2 + k / 3][c - 2 + k % 3];
        end
        expected_q.push_back(sum);
      end
    end
  endtask

  // Source sends only while it holds a credit
  task automatic stream_frame();
    int idx;
    int credits;
    idx = 0;
    while (idx < IMAGE_WIDTH * IMAGE_HEIGHT) begin
      @(posedge clk);
      credits = IN_DEPTH - driver_sent + pix_credits_seen;
      if (credits > 0 && $urandom_range(0, 3) != 0) begin
        pixel_valid <= 1'b1;
        pixel_data  <= pixel_t'(frame_pix[idx / IMAGE_WIDTH][idx % IMAGE_WIDTH]);
        driver_sent++;
        idx++;
      end else begin
        pixel_valid <= 1'b0;
      end
    end
    @(posedge clk);
    pixel_valid <= 1'b0;
  endtask

  task automatic run_frame();
    load_kernel();
    predict_frame();
    stream_frame();
    while (expected_q.size() != 0) begin
      @(posedge clk);
    end
  endtask

  // Mostly short with a long stall now and then
  function automatic int sink_delay();
    if ($urandom_range(0, 9) == 0) begin
      return 60 + int'($urandom_range(0, 60));
    end else begin
      return int'($urandom_range(0, 4));
    end
  endfunction

  ////////////////////////////////////////
  // Sink credit return and timeout
  ////////////////////////////////////////

  always @(posedge clk) begin
    cycle++;
    if (cycle > TIMEOUT_CYCLES) begin
      $display("Run stopped after %0d cycles with %0d results still missing",
               cycle, expected_q.size());
      print_summary();
      $display("*** TEST FAILED ***");
      $finish;
    end else if (credit_due.size() != 0 && credit_due[0] <= cycle) begin
      result_credit <= 1'b1;
      void'(credit_due.pop_front());
    end else begin
      result_credit <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  always @(negedge clk) begin : monitor
    int want;
    if (reset || after_reset) begin
      assert (!result_valid && !pix_credit)
        else flow_violation("result_valid or pix_credit high around reset");
    end
    after_reset = reset;

    if (pixel_valid) begin
      pixels_sent++;
    end
    if (pix_credit) begin
      pix_credits_seen++;
    end
    assert (pix_credits_seen <= pixels_sent)
      else flow_violation("more pixel credits returned than pixels sent");

    if (result_credit) begin
      result_credits_seen++;
    end
    if (result_valid) begin
      results_seen++;
      credit_due.push_back(cycle + sink_delay());
      assert (expected_q.size() != 0)
        else flow_violation("result arrived with no expected value left");
      if (expected_q.size() != 0) begin
        want = expected_q.pop_front();
        assert (int'(result_data) == want)
          else value_mismatch(int'(result_data), want);
      end
    end
    assert (results_seen <= OUT_CREDITS + result_credits_seen)
      else flow_violation("result sent without a sink credit");
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    void'($urandom(SEED));
    reset         = 1'b1;
    pixel_valid   = 1'b0;
    pixel_data    = '0;
    weight_wr     = 1'b0;
    weight_addr   = '0;
    weight_data   = '0;
    result_credit = 1'b0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;

    // Mixed weights on random pixels
    fill_random_kernel();
    fill_random_frame();
    run_frame();

    // Both ends of result_t
    fill_flat_kernel(-128);
    fill_flat_frame(255);
    run_frame();
    fill_flat_kernel(127);
    fill_flat_frame(255);
    run_frame();

    fill_random_kernel();
    fill_random_frame();
    run_frame();

    repeat (10) @(posedge clk);
    assert (pix_credits_seen == pixels_sent)
      else flow_violation("not every pixel was credited back");
    assert (results_seen == TOTAL_RESULTS)
      else flow_violation("result count differs from the window count");
    print_summary();
    if (value_errors == 0 && flow_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
logic/conv_pkg.sv
logic/flow_pkg.sv
logic/conv_window_if.sv
logic/pixel_queue.sv
logic/line_buffer.sv
logic/conv_3x3_core.sv
logic/result_queue.sv
logic/conv_engine_top.sv
verif/conv_engine_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= conv_engine_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
